//--- rtl/icache_cfg_pkg.sv
/* Instruction cache geometry */

`default_nettype none

package icache_cfg_pkg;

    // Fetch and line sizes.
    localparam int FETCH_WIDTH = 32;                             // One instruction word.
    localparam int LINE_WIDTH  = 128;                            // Four fetch words.
    localparam int WORDS_PER_LINE = LINE_WIDTH / FETCH_WIDTH;    // Refill beats per line.

    // Physical address split: | tag | index | offset |.
    localparam int ADDR_WIDTH   = 32;                            // Physical address.
    localparam int N_SETS       = 16;                            // Sets per way.
    localparam int OFFSET_WIDTH = 4;                             // Byte in line.
    localparam int INDEX_WIDTH  = $clog2(N_SETS);                // Set select.
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // Storage entry types, one per RAM kind.
    typedef logic [TAG_WIDTH-1:0]  tag_t;                        // Stored tag.
    typedef logic [LINE_WIDTH-1:0] line_t;                       // Stored line, word 0 lowest.

endpackage

`default_nettype wire

//--- rtl/icache_bus_pkg.sv
/* Fetch port and AXI4-Lite read channels */

`default_nettype none

package icache_bus_pkg;

    // Fetch request from the front end.
    typedef struct packed {
        logic [icache_cfg_pkg::ADDR_WIDTH-1:0] addr;            // Word aligned.
    } fetch_req_t;

    // Fetch response back to the front end.
    typedef struct packed {
        logic [icache_cfg_pkg::FETCH_WIDTH-1:0] data;           // Instruction word.
    } fetch_rsp_t;

    // AXI4-Lite read address channel payload.
    typedef struct packed {
        logic [icache_cfg_pkg::ADDR_WIDTH-1:0] addr;            // Byte address of the beat.
        logic [2:0]                            prot;            // Access attributes.
    } axil_ar_t;

    // AXI4-Lite read data channel payload.
    typedef struct packed {
        logic [icache_cfg_pkg::FETCH_WIDTH-1:0] data;           // Read word.
        logic [1:0]                             resp;           // OKAY, SLVERR, ...
    } axil_r_t;

    // Unprivileged, secure, instruction access.
    localparam logic [2:0] AXI_PROT_INSN = 3'b100;

endpackage

`default_nettype wire

//--- rtl/icache_way_ram.sv
/* Cache way storage */

`timescale 1ns/1ps
`default_nettype none

module icache_way_ram #(
    parameter type entry_t = icache_cfg_pkg::tag_t
) (
    input  logic                                   clk_i,
    input  logic [icache_cfg_pkg::INDEX_WIDTH-1:0] rd_idx_i,    // Sampled on the edge.
    output entry_t                                 rd_data_o,   // Valid one cycle later.
    input  logic                                   wr_en_i,
    input  logic [icache_cfg_pkg::INDEX_WIDTH-1:0] wr_idx_i,
    input  entry_t                                 wr_data_i
);

    import icache_cfg_pkg::*;

    entry_t mem_q [N_SETS];                                     // One entry per set.

    // Synchronous write.
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

    // Registered read, new data wins when both hit the same set.
    // The re-lookup after a refill depends on this.
    always_ff @(posedge clk_i) begin
        if (wr_en_i && (wr_idx_i == rd_idx_i)) begin
            rd_data_o <= wr_data_i;                             // Write-first bypass.
        end else begin
            rd_data_o <= mem_q[rd_idx_i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache_tzc_idx.sv
/* Hit vector encoder */

`timescale 1ns/1ps
`default_nettype none

module icache_tzc_idx #(
    parameter int N_WAY = 4
) (
    input  logic [N_WAY-1:0]         in_i,                      // One-hot hit vector.
    output logic [$clog2(N_WAY)-1:0] way_o                      // Index of lowest set bit.
);

    localparam int WAY_W = $clog2(N_WAY);

    // Scan from the top so the lowest set bit is the last to write.
    always_comb begin
        way_o = '0;                                             // Way 0 when nothing hits.
        for (int i = N_WAY - 1; i >= 0; i--) begin
            if (in_i[i]) begin
                way_o = WAY_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache_checker.sv
/* Instruction cache way checker */

`timescale 1ns/1ps
`default_nettype none

module icache_checker #(
    parameter int N_WAY = 4
) (
    input  icache_cfg_pkg::tag_t                    cline_tag_i,      // Fetch tag, registered.
    input  logic [1:0]                              fetch_idx_i,      // Word within line.
    input  logic [N_WAY-1:0]                        way_valid_bits_i, // Valid bits of the set.
    input  icache_cfg_pkg::tag_t [N_WAY-1:0]        read_tags_i,      // Stored tags.
    input  icache_cfg_pkg::line_t [N_WAY-1:0]       data_rd_i,        // Stored lines.
    output logic [N_WAY-1:0]                        cline_hit_o,      // One-hot on a hit.
    output logic [icache_cfg_pkg::FETCH_WIDTH-1:0]  data_o            // Word of hitting way.
);

    import icache_cfg_pkg::*;

    localparam int WAY_W = $clog2(N_WAY);

    logic [WAY_W-1:0]                  hit_way;                 // Encoded hit.
    logic [N_WAY-1:0][FETCH_WIDTH-1:0] way_word;                // Selected word per way.

    // Pick one fetch word out of a line.
    function automatic logic [FETCH_WIDTH-1:0] word_of(
        input line_t      line,
        input logic [1:0] sel
    );
        return line[sel*FETCH_WIDTH +: FETCH_WIDTH];
    endfunction

    for (genvar w = 0; w < N_WAY; w++) begin : g_way
        assign cline_hit_o[w] = way_valid_bits_i[w]
                              & (read_tags_i[w] == cline_tag_i); // Tag match, valid only.
        assign way_word[w]    = word_of(data_rd_i[w], fetch_idx_i);
    end

    // Hit vector to way number.
    icache_tzc_idx #(
        .N_WAY (N_WAY)
    ) tzc_idx (
        .in_i  (cline_hit_o),
        .way_o (hit_way)
    );

    assign data_o = way_word[hit_way];                          // Meaningless on a miss.

endmodule

`default_nettype wire

//--- rtl/icache_ctrl.sv
/* Instruction cache controller */

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int N_WAY = 4
) (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic                                   flush_i,
    input  logic                                   fetch_req_valid_i,
    input  icache_bus_pkg::fetch_req_t             fetch_req_i,
    output logic                                   fetch_req_ready_o,
    output logic                                   fetch_rsp_valid_o,
    output icache_bus_pkg::fetch_rsp_t             fetch_rsp_o,
    input  logic                                   fetch_rsp_ready_i,
    output logic                                   axil_ar_valid_o,
    output icache_bus_pkg::axil_ar_t               axil_ar_o,
    input  logic                                   axil_ar_ready_i,
    input  logic                                   axil_r_valid_i,
    input  icache_bus_pkg::axil_r_t                axil_r_i,
    output logic                                   axil_r_ready_o,
    output logic [icache_cfg_pkg::INDEX_WIDTH-1:0] ram_rd_idx_o,
    output logic [N_WAY-1:0]                       ram_wr_en_o,
    output logic [icache_cfg_pkg::INDEX_WIDTH-1:0] ram_wr_idx_o,
    output icache_cfg_pkg::tag_t                   ram_wr_tag_o,
    output icache_cfg_pkg::line_t                  ram_wr_line_o,
    output logic [N_WAY-1:0]                       way_valid_bits_o,
    output icache_cfg_pkg::tag_t                   cline_tag_o,
    output logic [1:0]                             fetch_idx_o,
    input  logic [N_WAY-1:0]                       cline_hit_i,
    input  logic [icache_cfg_pkg::FETCH_WIDTH-1:0] data_i
);

    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int WAY_W = $clog2(N_WAY);

    typedef enum logic [2:0] {
        st_idle, st_lookup, st_refill, st_write, st_resp
    } state_e;

    state_e                        state_q;
    fetch_req_t                    req_q;                       // Accepted fetch.
    fetch_rsp_t                    rsp_q;                       // Held response.
    line_t                         line_q;                      // Refill shift register.
    logic [1:0]                    word_cnt_q;                  // Refill beat.
    logic                          ar_valid_q;
    logic [N_SETS-1:0][N_WAY-1:0]  valid_q;                     // Valid bit per way and set.
    logic [N_SETS-1:0][WAY_W-1:0]  rr_q;                        // Round-robin victim per set.
    logic [INDEX_WIDTH-1:0]        req_idx;
    logic [WAY_W-1:0]              victim;
    logic                          accept;
    logic                          ar_fire;
    logic                          r_fire;

    assign req_idx     = req_q.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign victim      = rr_q[req_idx];
    assign cline_tag_o = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign fetch_idx_o = req_q.addr[OFFSET_WIDTH-1:2];          // Word in line.

    // Fetch handshake. Flush takes the idle cycle.
    assign fetch_req_ready_o = (state_q == st_idle) && !flush_i;
    assign accept            = fetch_req_valid_i && fetch_req_ready_o;
    assign fetch_rsp_valid_o = (state_q == st_resp);
    assign fetch_rsp_o       = rsp_q;

    // Memory reads, one beat outstanding at a time.
    assign axil_ar_valid_o = ar_valid_q;
    assign axil_ar_o       = '{addr: {req_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH], word_cnt_q, 2'b00},
                               prot: AXI_PROT_INSN};
    assign axil_r_ready_o  = (state_q == st_refill) && !ar_valid_q;
    assign ar_fire         = axil_ar_valid_o && axil_ar_ready_i;
    assign r_fire          = axil_r_valid_i && axil_r_ready_o;

    // RAM read follows the incoming fetch while idle.
    assign ram_rd_idx_o     = (state_q == st_idle) ? fetch_req_i.addr[OFFSET_WIDTH +: INDEX_WIDTH]
                                                   : req_idx;
    assign ram_wr_idx_o     = req_idx;
    assign ram_wr_tag_o     = cline_tag_o;
    assign ram_wr_line_o    = line_q;
    assign way_valid_bits_o = valid_q[req_idx];

    for (genvar w = 0; w < N_WAY; w++) begin : g_wr_en
        assign ram_wr_en_o[w] = (state_q == st_write) && (victim == WAY_W'(w)); // Victim only.
    end

    // Control state.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= st_idle;
            word_cnt_q <= '0;
            ar_valid_q <= 1'b0;
            valid_q    <= '0;                                   // Cache starts empty.
            rr_q       <= '0;
        end else begin
            unique case (state_q)
                st_idle: begin
                    if (flush_i) begin
                        valid_q <= '0;                          // Invalidate everything.
                        rr_q    <= '0;
                    end else if (accept) begin
                        state_q <= st_lookup;                   // RAM read in flight.
                    end
                end
                st_lookup: begin
                    if (|cline_hit_i) begin
                        state_q <= st_resp;
                    end else begin
                        state_q    <= st_refill;                // Miss, fetch the line.
                        word_cnt_q <= '0;
                        ar_valid_q <= 1'b1;
                    end
                end
                st_refill: begin
                    if (ar_fire) begin
                        ar_valid_q <= 1'b0;                     // Now wait for R.
                    end
                    if (r_fire) begin
                        word_cnt_q <= word_cnt_q + 2'd1;
                        if (word_cnt_q == 2'(WORDS_PER_LINE - 1)) begin
                            state_q <= st_write;                // Line complete.
                        end else begin
                            ar_valid_q <= 1'b1;                 // Next beat.
                        end
                    end
                end
                st_write: begin
                    valid_q[req_idx][victim] <= 1'b1;
                    rr_q[req_idx]            <= victim + 1'b1;  // Wraps at N_WAY.
                    state_q                  <= st_lookup;      // Re-run the lookup.
                end
                st_resp: begin
                    if (fetch_rsp_ready_i) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Payload registers.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= fetch_req_i;
        end
        if (r_fire) begin
            line_q <= {axil_r_i.data, line_q[LINE_WIDTH-1:FETCH_WIDTH]}; // Fill from the top.
        end
        if ((state_q == st_lookup) && (|cline_hit_i)) begin
            rsp_q.data <= data_i;                               // Hold until taken.
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
/* Set-associative instruction cache */

`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int N_WAY = 4
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       flush_i,
    input  logic                       fetch_req_valid_i,
    input  icache_bus_pkg::fetch_req_t fetch_req_i,
    output logic                       fetch_req_ready_o,
    output logic                       fetch_rsp_valid_o,
    output icache_bus_pkg::fetch_rsp_t fetch_rsp_o,
    input  logic                       fetch_rsp_ready_i,
    output logic                       axil_ar_valid_o,
    output icache_bus_pkg::axil_ar_t   axil_ar_o,
    input  logic                       axil_ar_ready_i,
    input  logic                       axil_r_valid_i,
    input  icache_bus_pkg::axil_r_t    axil_r_i,
    output logic                       axil_r_ready_o
);

    import icache_cfg_pkg::*;

    logic [INDEX_WIDTH-1:0]  ram_rd_idx;                        // Shared by all RAMs.
    logic [INDEX_WIDTH-1:0]  ram_wr_idx;
    logic [N_WAY-1:0]        ram_wr_en;                         // One per way.
    tag_t                    ram_wr_tag;
    line_t                   ram_wr_line;
    tag_t [N_WAY-1:0]        read_tags;
    line_t [N_WAY-1:0]       read_lines;
    logic [N_WAY-1:0]        way_valid_bits;
    logic [N_WAY-1:0]        cline_hit;
    tag_t                    cline_tag;
    logic [1:0]              fetch_idx;
    logic [FETCH_WIDTH-1:0]  fetch_word;

    icache_ctrl #(
        .N_WAY (N_WAY)
    ) ctrl (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .flush_i           (flush_i),
        .fetch_req_valid_i (fetch_req_valid_i),
        .fetch_req_i       (fetch_req_i),
        .fetch_req_ready_o (fetch_req_ready_o),
        .fetch_rsp_valid_o (fetch_rsp_valid_o),
        .fetch_rsp_o       (fetch_rsp_o),
        .fetch_rsp_ready_i (fetch_rsp_ready_i),
        .axil_ar_valid_o   (axil_ar_valid_o),
        .axil_ar_o         (axil_ar_o),
        .axil_ar_ready_i   (axil_ar_ready_i),
        .axil_r_valid_i    (axil_r_valid_i),
        .axil_r_i          (axil_r_i),
        .axil_r_ready_o    (axil_r_ready_o),
        .ram_rd_idx_o      (ram_rd_idx),
        .ram_wr_en_o       (ram_wr_en),
        .ram_wr_idx_o      (ram_wr_idx),
        .ram_wr_tag_o      (ram_wr_tag),
        .ram_wr_line_o     (ram_wr_line),
        .way_valid_bits_o  (way_valid_bits),
        .cline_tag_o       (cline_tag),
        .fetch_idx_o       (fetch_idx),
        .cline_hit_i       (cline_hit),
        .data_i            (fetch_word)
    );

    icache_checker #(
        .N_WAY (N_WAY)
    ) way_check (
        .cline_tag_i      (cline_tag),
        .fetch_idx_i      (fetch_idx),
        .way_valid_bits_i (way_valid_bits),
        .read_tags_i      (read_tags),
        .data_rd_i        (read_lines),
        .cline_hit_o      (cline_hit),
        .data_o           (fetch_word)
    );

    // Tag and line storage, one pair per way.
    for (genvar w = 0; w < N_WAY; w++) begin : g_way
        icache_way_ram #(
            .entry_t (tag_t)
        ) tag_ram (
            .clk_i     (clk_i),
            .rd_idx_i  (ram_rd_idx),
            .rd_data_o (read_tags[w]),
            .wr_en_i   (ram_wr_en[w]),
            .wr_idx_i  (ram_wr_idx),
            .wr_data_i (ram_wr_tag)
        );

        icache_way_ram #(
            .entry_t (line_t)
        ) line_ram (
            .clk_i     (clk_i),
            .rd_idx_i  (ram_rd_idx),
            .rd_data_o (read_lines[w]),
            .wr_en_i   (ram_wr_en[w]),
            .wr_idx_i  (ram_wr_idx),
            .wr_data_i (ram_wr_line)
        );
    end

endmodule

`default_nettype wire

//--- testbench/icache_tb_clk.sv
/* Testbench clock */

`timescale 1ns/1ps
`default_nettype none

module icache_tb_clk #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;                                           // Rising edge at half period.
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- testbench/icache_props.sv
/* Cache handshake assertions */

`timescale 1ns/1ps
`default_nettype none

module icache_props (
    input logic                       clk_i,
    input logic                       reset_i,
    input logic                       req_ready_i,
    input logic                       rsp_valid_i,
    input icache_bus_pkg::fetch_rsp_t rsp_i,
    input logic                       rsp_ready_i,
    input logic                       ar_valid_i,
    input icache_bus_pkg::axil_ar_t   ar_i,
    input logic                       ar_ready_i
);

    // A stalled AR beat keeps valid and payload.
    a_ar_held: assert property (@(posedge clk_i) disable iff (reset_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
        else $error("AR valid or payload changed before ready");

    // Back-pressured response is held.
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else $error("Fetch response changed before it was taken");

    a_no_req_in_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_i |-> !req_ready_i)
        else $error("Request port ready while a response is pending");

endmodule

bind icache_top icache_props props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_ready_i (fetch_req_ready_o),
    .rsp_valid_i (fetch_rsp_valid_o),
    .rsp_i       (fetch_rsp_o),
    .rsp_ready_i (fetch_rsp_ready_i),
    .ar_valid_i  (axil_ar_valid_o),
    .ar_i        (axil_ar_o),
    .ar_ready_i  (axil_ar_ready_i)
);

`default_nettype wire

//--- testbench/icache_tb.sv
/* Instruction cache testbench */

`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int N_WAY          = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int MAX_DELAY      = 3;                          // Memory AR and R stall.
    localparam int MAX_STRETCH    = 4;                          // Response back-pressure.
    localparam int N_RANDOM       = 40;
    localparam int N_FETCHES      = 16 + N_RANDOM;
    localparam int MISS_CYCLES    = 6 + 4 * (2 * MAX_DELAY + 4) + MAX_STRETCH;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + (N_FETCHES + 2) * MISS_CYCLES;
    localparam logic [2:0] INSN_PROT = 3'b100;                  // AXI instruction access.

    logic       clk;
    logic       reset;
    logic       flush;
    logic       req_valid;
    fetch_req_t req;
    logic       req_ready;
    logic       rsp_valid;
    fetch_rsp_t rsp;
    logic       rsp_ready;
    logic       ar_valid;
    axil_ar_t   ar;
    logic       ar_ready;
    logic       r_valid;
    axil_r_t    r;
    logic       r_ready;

    integer     seed = 92954;
    tag_t       ref_tag   [N_SETS][N_WAY];                      // Reference cache contents.
    logic       ref_valid [N_SETS][N_WAY];
    int         ref_rr    [N_SETS];                             // Next victim per set.
    axil_ar_t   ar_exp_q[$];                                    // Refill reads still due.
    fetch_rsp_t exp_rsp_q[$];                                   // One entry per fetch.
    int         exp_ars_q[$];
    string      exp_name_q[$];
    int         neg_cnt = 0;
    int         accept_cyc = 0;
    int         ar_count = 0;
    logic       rsp_first = 1'b0;

    icache_tb_clk #(.PERIOD_NS (20)) clk_gen (.clk_o (clk));

    icache_top #(
        .N_WAY (N_WAY)
    ) UUT (
        .clk_i             (clk),
        .reset_i           (reset),
        .flush_i           (flush),
        .fetch_req_valid_i (req_valid),
        .fetch_req_i       (req),
        .fetch_req_ready_o (req_ready),
        .fetch_rsp_valid_o (rsp_valid),
        .fetch_rsp_o       (rsp),
        .fetch_rsp_ready_i (rsp_ready),
        .axil_ar_valid_o   (ar_valid),
        .axil_ar_o         (ar),
        .axil_ar_ready_i   (ar_ready),
        .axil_r_valid_i    (r_valid),
        .axil_r_i          (r),
        .axil_r_ready_o    (r_ready)
    );

    // Memory contents, a scramble of the whole address.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_0F0F;
    endfunction

    // Way holding the address in the reference, -1 on a miss.
    function automatic int ref_lookup(input logic [31:0] addr);
        logic [INDEX_WIDTH-1:0] set;
        int                     way;
        set = addr[OFFSET_WIDTH +: INDEX_WIDTH];
        way = -1;
        for (int w = 0; w < N_WAY; w++) begin
            if (ref_valid[set][w] && (ref_tag[set][w] == addr[ADDR_WIDTH-1 -: TAG_WIDTH])) begin
                way = w;
            end
        end
        return way;
    endfunction

    task automatic ref_clear();
        for (int s = 0; s < N_SETS; s++) begin
            ref_rr[s] = 0;
            for (int w = 0; w < N_WAY; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
    endtask

    // Miss: queue four word reads, then place the line in the round-robin victim.
    task automatic ref_fill(input logic [31:0] addr);
        logic [INDEX_WIDTH-1:0] set;
        axil_ar_t               exp_ar;
        set = addr[OFFSET_WIDTH +: INDEX_WIDTH];
        for (int b = 0; b < 4; b++) begin
            exp_ar.addr = {addr[ADDR_WIDTH-1:OFFSET_WIDTH], 4'h0} + 32'(4 * b);
            exp_ar.prot = INSN_PROT;
            ar_exp_q.push_back(exp_ar);
        end
        ref_tag[set][ref_rr[set]]   = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
        ref_valid[set][ref_rr[set]] = 1'b1;
        ref_rr[set]                 = (ref_rr[set] + 1) % N_WAY;
    endtask

    task automatic fail_and_stop();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_fetch_rsp(input string name, input fetch_rsp_t exp, input fetch_rsp_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            fail_and_stop();
        end
    endtask

    task automatic check_axil_ar(input string name, input axil_ar_t exp, input axil_ar_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            fail_and_stop();
        end
    endtask

    task automatic check_refill_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s refill reads: expected %0d, actual %0d", name, exp, act);
            fail_and_stop();
        end
    endtask

    task automatic check_hit_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s hit latency: expected %0d, actual %0d", name, exp, act);
            fail_and_stop();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Record the expectation, then hold the request until it is taken.
    task automatic issue_fetch(input string test, input logic [31:0] addr);
        fetch_rsp_t exp_rsp;
        int         n_ars;
        logic       taken;
        n_ars = 0;
        if (ref_lookup(addr) < 0) begin
            ref_fill(addr);
            n_ars = 4;
        end
        exp_rsp.data = mem_word(addr);
        exp_name_q.push_back($sformatf("%s %h", test, addr));
        exp_rsp_q.push_back(exp_rsp);
        exp_ars_q.push_back(n_ars);
        req_valid = 1'b1;
        req.addr  = addr;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;                                  // Transfer at the next edge.
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    // Controller is idle once the last response has been taken.
    task automatic flush_cache();
        while (exp_rsp_q.size() != 0) begin
            wait_cycles(1);
        end
        flush = 1'b1;
        @(negedge clk);
        if (req_ready) begin
            $display("ERROR: request port ready during a flush");
            fail_and_stop();
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
        ref_clear();
    endtask

    initial begin : stimulus
        logic [ADDR_WIDTH-1:0] addr;
        int                    tag_sel;
        int                    set_sel;
        int                    word_sel;
        reset     = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        ref_clear();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (!req_ready || rsp_valid || ar_valid) begin
            $display("ERROR: cache outputs not idle after reset");
            fail_and_stop();
        end
        @(posedge clk);
        #1;
        issue_fetch("first_touch", 32'h0000_1230);
        issue_fetch("resident", 32'h0000_1234);
        issue_fetch("resident", 32'h0000_1238);
        issue_fetch("resident", 32'h0000_123C);
        issue_fetch("resident", 32'h0000_1230);
        // N_WAY + 1 tags in set 5, then one evicted and the retained ones.
        for (int t = 0; t <= N_WAY; t++) begin
            issue_fetch("evict", {24'(24'h00_A000 + t), 4'h5, 4'h0});
        end
        issue_fetch("evicted", {24'h00_A000, 4'h5, 4'h0});
        for (int t = 2; t <= N_WAY; t++) begin
            issue_fetch("retained", {24'(24'h00_A000 + t), 4'h5, 4'h0});
        end
        flush_cache();
        issue_fetch("after_flush", 32'h0000_1230);
        issue_fetch("after_flush", 32'h0000_1234);
        // Six tags over four sets, so hits and evictions mix.
        for (int i = 0; i < N_RANDOM; i++) begin
            tag_sel  = $unsigned($random(seed)) % 6;
            set_sel  = $unsigned($random(seed)) % 4;
            word_sel = $unsigned($random(seed)) % 4;
            addr     = {24'(24'h00_0800 + tag_sel), 4'(set_sel), 2'(word_sel), 2'b00};
            issue_fetch("random", addr);
        end
        while (exp_rsp_q.size() != 0) begin
            wait_cycles(1);
        end
        wait_cycles(4);
        if (ar_exp_q.size() != 0) begin
            $display("ERROR: %0d expected refill reads were never issued", ar_exp_q.size());
            fail_and_stop();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // AXI4-Lite read memory, one beat at a time.
    initial begin : memory_model
        logic [31:0] addr;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        wait_cycles(RESET_CYCLES + 1);
        forever begin
            wait_cycles($unsigned($random(seed)) % (MAX_DELAY + 1));
            ar_ready = 1'b1;
            @(negedge clk);
            while (!ar_valid) begin
                @(negedge clk);
            end
            addr = ar.addr;
            @(posedge clk);
            #1;
            ar_ready = 1'b0;
            wait_cycles($unsigned($random(seed)) % (MAX_DELAY + 1));
            r_valid = 1'b1;
            r.data  = mem_word(addr);
            r.resp  = 2'b00;                                    // OKAY.
            @(negedge clk);
            while (!r_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            r_valid = 1'b0;
        end
    end

    // Response ready toggles in random stretches.
    initial begin : backpressure
        int stretch;
        stretch   = 0;
        rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (stretch == 0) begin
                rsp_ready = !rsp_ready;
                stretch   = 1 + int'($unsigned($random(seed)) % MAX_STRETCH);
            end
            stretch = stretch - 1;
        end
    end

    // Compare at the falling edge where everything is settled.
    always @(negedge clk) begin
        if (!reset) begin
            neg_cnt = neg_cnt + 1;
            if (req_valid && req_ready) begin
                accept_cyc = neg_cnt;
                ar_count   = 0;
                rsp_first  = 1'b1;
            end
            if (ar_valid && ar_ready) begin
                if (ar_exp_q.size() == 0) begin
                    $display("ERROR: AR read to %h while no refill is due", ar.addr);
                    fail_and_stop();
                end else begin
                    check_axil_ar(exp_name_q[0], ar_exp_q[0], ar);
                    ar_exp_q.delete(0);
                    ar_count = ar_count + 1;
                end
            end
            if (rsp_valid) begin
                if (req_ready) begin
                    $display("ERROR: request port ready while a response is pending");
                    fail_and_stop();
                end else if (exp_rsp_q.size() == 0) begin
                    $display("ERROR: response with no fetch outstanding");
                    fail_and_stop();
                end else begin
                    check_fetch_rsp(exp_name_q[0], exp_rsp_q[0], rsp);
                    if (rsp_first && (exp_ars_q[0] == 0)) begin
                        check_hit_latency(exp_name_q[0], 2, neg_cnt - accept_cyc);
                    end
                    rsp_first = 1'b0;
                    if (rsp_ready) begin
                        check_refill_count(exp_name_q[0], exp_ars_q[0], ar_count);
                        exp_name_q.delete(0);
                        exp_rsp_q.delete(0);
                        exp_ars_q.delete(0);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("ERROR: timeout, run did not finish in %0d cycles", TIMEOUT_CYCLES);
                fail_and_stop();
            end
        end
    end

endmodule

`default_nettype wire

//--- icache_top.f
rtl/icache_cfg_pkg.sv
rtl/icache_bus_pkg.sv
rtl/icache_way_ram.sv
rtl/icache_tzc_idx.sv
rtl/icache_checker.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
testbench/icache_tb_clk.sv
testbench/icache_props.sv
testbench/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icache_tb -Mdir "$BUILD_DIR" -f icache_top.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vicache_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"
exit 0
